//--- rtl/rob_settings.svh
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer depth, tag 0 is reserved for "no entry"
`define ROB_SIZE  15
`define ROB_TAG_W 4

// data and address words
`define DATA_W    32

// 32 architectural registers, x0 hardwired to zero
`define REG_W     5

// major opcode field of the instruction word
`define OP_LO     0
`define OP_HI     6

`endif

//--- rtl/rob_pkg.sv
`include "rob_settings.svh"

package rob_pkg;

    // rename tag, 0 means no pending producer
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    typedef logic [`DATA_W-1:0] data_t;

    typedef logic [`REG_W-1:0] reg_idx_t;

    // RV32I major opcodes seen at commit
    typedef enum logic [`OP_HI-`OP_LO:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // what retiring the head entry does
    typedef enum logic [1:0] {
        CK_REG    = 2'd0,
        CK_STORE  = 2'd1,
        CK_BRANCH = 2'd2,
        CK_JALR   = 2'd3
    } commit_kind_e;

endpackage

//--- rtl/rob_buffer.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_valid,
    input  rob_pkg::data_t    alloc_inst,
    input  rob_pkg::reg_idx_t alloc_dest,
    input  rob_pkg::data_t    alloc_pc,
    input  logic              alloc_pred_taken,
    input  rob_pkg::rob_tag_t alu_cdb_tag,
    input  rob_pkg::data_t    alu_cdb_value,
    input  logic              alu_cdb_taken,
    input  rob_pkg::data_t    alu_cdb_target,
    input  rob_pkg::rob_tag_t ld_cdb_tag,
    input  rob_pkg::data_t    ld_cdb_value,
    input  logic              flush,
    input  rob_pkg::rob_tag_t query1_tag,
    input  rob_pkg::rob_tag_t query2_tag,
    output rob_pkg::rob_tag_t alloc_tag,
    output logic              alloc_fire,
    output logic              query1_ready,
    output rob_pkg::data_t    query1_value,
    output logic              query2_ready,
    output rob_pkg::data_t    query2_value,
    output logic              head_ready,
    output rob_pkg::rob_tag_t head_tag,
    output rob_pkg::data_t    head_inst,
    output rob_pkg::reg_idx_t head_dest,
    output rob_pkg::data_t    head_pc,
    output rob_pkg::data_t    head_value,
    output logic              head_taken,
    output rob_pkg::data_t    head_target,
    output logic              head_pred_taken
);
    import rob_pkg::*;

    // per-entry storage, slot 0 never holds an entry
    data_t    inst_q   [0:`ROB_SIZE];
    reg_idx_t dest_q   [0:`ROB_SIZE];
    data_t    pc_q     [0:`ROB_SIZE];
    logic     pred_q   [0:`ROB_SIZE];
    logic     taken_q  [0:`ROB_SIZE];
    data_t    target_q [0:`ROB_SIZE];
    data_t    value_q  [0:`ROB_SIZE];
    logic     ready_q  [0:`ROB_SIZE];

    rob_tag_t               head_q;
    rob_tag_t               tail_q;
    logic [`ROB_TAG_W-1:0] count_q;
    logic                   full;
    logic                   retire;

    // pointers wrap from the last slot back to 1
    function automatic rob_tag_t next_tag(input rob_tag_t t);
        if (t == rob_tag_t'(`ROB_SIZE)) begin
            return rob_tag_t'(1);
        end
        return t + rob_tag_t'(1);
    endfunction

    assign full       = (count_q == `ROB_TAG_W'(`ROB_SIZE));
    assign alloc_tag  = (full || flush) ? '0 : tail_q;
    assign alloc_fire = alloc_valid && (alloc_tag != '0);

    // count gates out stale ready bits of old slots
    assign retire     = (count_q != '0) && ready_q[head_q];
    assign head_ready = retire;

    assign head_tag        = head_q;
    assign head_inst       = inst_q[head_q];
    assign head_dest       = dest_q[head_q];
    assign head_pc         = pc_q[head_q];
    assign head_value      = value_q[head_q];
    assign head_taken      = taken_q[head_q];
    assign head_target     = target_q[head_q];
    assign head_pred_taken = pred_q[head_q];

    // decoder operand lookups
    assign query1_ready = ready_q[query1_tag];
    assign query1_value = value_q[query1_tag];
    assign query2_ready = ready_q[query2_tag];
    assign query2_value = value_q[query2_tag];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_q  <= rob_tag_t'(1);
            tail_q  <= rob_tag_t'(1);
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                tail_q <= next_tag(tail_q);
            end
            if (retire) begin
                head_q <= next_tag(head_q);
            end
            case ({alloc_fire, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ready bits, dropped wholesale on flush
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i <= `ROB_SIZE; i++) begin
                ready_q[i] <= 1'b0;
            end
        end else begin
            if (alloc_fire) begin
                ready_q[tail_q] <= 1'b0;
            end
            if (alu_cdb_tag != '0) begin
                ready_q[alu_cdb_tag] <= 1'b1;
            end
            if (ld_cdb_tag != '0) begin
                ready_q[ld_cdb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            inst_q[tail_q] <= alloc_inst;
            dest_q[tail_q] <= alloc_dest;
            pc_q[tail_q]   <= alloc_pc;
            pred_q[tail_q] <= alloc_pred_taken;
        end
        // ALU bus also carries branch outcome
        if (alu_cdb_tag != '0) begin
            value_q[alu_cdb_tag]  <= alu_cdb_value;
            taken_q[alu_cdb_tag]  <= alu_cdb_taken;
            target_q[alu_cdb_tag] <= alu_cdb_target;
        end
        if (ld_cdb_tag != '0) begin
            value_q[ld_cdb_tag] <= ld_cdb_value;
        end
    end

endmodule

//--- rtl/rob_commit.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_commit (
    input  logic              clk,
    input  logic              rst,
    input  logic              head_ready,
    input  rob_pkg::rob_tag_t head_tag,
    input  rob_pkg::data_t    head_inst,
    input  rob_pkg::reg_idx_t head_dest,
    input  rob_pkg::data_t    head_pc,
    input  rob_pkg::data_t    head_value,
    input  logic              head_taken,
    input  rob_pkg::data_t    head_target,
    input  logic              head_pred_taken,
    output logic              flush,
    output logic              reg_we,
    output rob_pkg::reg_idx_t reg_idx,
    output rob_pkg::rob_tag_t reg_tag,
    output rob_pkg::data_t    reg_value,
    output logic              wb_valid,
    output rob_pkg::reg_idx_t wb_reg,
    output rob_pkg::rob_tag_t wb_tag,
    output rob_pkg::data_t    wb_value,
    output logic              store_commit_valid,
    output rob_pkg::rob_tag_t store_commit_tag,
    output logic              bp_update_valid,
    output rob_pkg::data_t    bp_pc,
    output logic              bp_taken,
    output logic              redirect_valid,
    output rob_pkg::data_t    redirect_pc
);
    import rob_pkg::*;

    opcode_e      opcode;
    commit_kind_e kind;
    logic         mispredict;
    logic         is_jalr;
    data_t        fix_pc;

    assign opcode = opcode_e'(head_inst[`OP_HI:`OP_LO]);

    always_comb begin
        case (opcode)
            OP, OP_IMM, LUI, AUIPC, LOAD, JAL: kind = CK_REG;
            STORE:   kind = CK_STORE;
            BRANCH:  kind = CK_BRANCH;
            JALR:    kind = CK_JALR;
            default: kind = CK_REG;
        endcase
    end

    assign is_jalr    = (kind == CK_JALR);
    assign mispredict = (kind == CK_BRANCH) && (head_taken != head_pred_taken);

    // a jalr target is never predicted here
    assign fix_pc = (is_jalr || head_taken) ? head_target : head_pc + 32'd4;
    assign flush  = head_ready && (mispredict || is_jalr);

    // write port into the register file, same edge as retire
    assign reg_we    = head_ready && (kind == CK_REG || is_jalr) && (head_dest != '0);
    assign reg_idx   = head_dest;
    assign reg_tag   = head_tag;
    assign reg_value = head_value;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid           <= 1'b0;
            store_commit_valid <= 1'b0;
            bp_update_valid    <= 1'b0;
            redirect_valid     <= 1'b0;
        end else begin
            wb_valid           <= reg_we;
            store_commit_valid <= head_ready && (kind == CK_STORE);
            bp_update_valid    <= head_ready && (kind == CK_BRANCH || is_jalr);
            redirect_valid     <= flush;
        end
    end

    // payloads only meaningful alongside their strobe
    always_ff @(posedge clk) begin
        wb_reg           <= reg_idx;
        wb_tag           <= reg_tag;
        wb_value         <= reg_value;
        store_commit_tag <= head_tag;
        bp_pc            <= head_pc;
        bp_taken         <= is_jalr || head_taken;
        redirect_pc      <= fix_pc;
    end

endmodule

//--- rtl/reg_rename.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module reg_rename (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_fire,
    input  rob_pkg::reg_idx_t alloc_dest,
    input  rob_pkg::rob_tag_t alloc_tag,
    input  logic              wb_we,
    input  rob_pkg::reg_idx_t wb_reg,
    input  rob_pkg::rob_tag_t wb_tag,
    input  rob_pkg::data_t    wb_value,
    input  logic              flush,
    input  rob_pkg::reg_idx_t src1_reg,
    input  rob_pkg::reg_idx_t src2_reg,
    input  logic              query1_ready,
    input  rob_pkg::data_t    query1_value,
    input  logic              query2_ready,
    input  rob_pkg::data_t    query2_value,
    output rob_pkg::rob_tag_t query1_tag,
    output rob_pkg::rob_tag_t query2_tag,
    output logic              src1_ready,
    output rob_pkg::data_t    src1_value,
    output rob_pkg::rob_tag_t src1_tag,
    output logic              src2_ready,
    output rob_pkg::data_t    src2_value,
    output rob_pkg::rob_tag_t src2_tag
);
    import rob_pkg::*;

    // architectural state and pending producer per register
    data_t    regs_q [0:(1 << `REG_W) - 1];
    rob_tag_t tags_q [0:(1 << `REG_W) - 1];

    // x0 is reset to zero and never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_W); i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_we && wb_reg != '0) begin
            regs_q[wb_reg] <= wb_value;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            for (int i = 0; i < (1 << `REG_W); i++) begin
                tags_q[i] <= '0;
            end
        end else begin
            // only the latest producer may clear its own tag
            if (wb_we && tags_q[wb_reg] == wb_tag) begin
                tags_q[wb_reg] <= '0;
            end
            // later assignment wins, a new dispatch keeps its tag
            if (alloc_fire && alloc_dest != '0) begin
                tags_q[alloc_dest] <= alloc_tag;
            end
        end
    end

    assign query1_tag = tags_q[src1_reg];
    assign query2_tag = tags_q[src2_reg];

    // tag 0 reads the register file, otherwise the buffer entry
    assign src1_tag   = query1_tag;
    assign src1_ready = (query1_tag == '0) || query1_ready;
    assign src1_value = (query1_tag == '0) ? regs_q[src1_reg] : query1_value;

    assign src2_tag   = query2_tag;
    assign src2_ready = (query2_tag == '0) || query2_ready;
    assign src2_value = (query2_tag == '0) ? regs_q[src2_reg] : query2_value;

endmodule

//--- rtl/rob_core.sv
`timescale 1ns/1ns

module rob_core (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_valid,
    input  rob_pkg::data_t    alloc_inst,
    input  rob_pkg::reg_idx_t alloc_dest,
    input  rob_pkg::data_t    alloc_pc,
    input  logic              alloc_pred_taken,
    input  rob_pkg::rob_tag_t alu_cdb_tag,
    input  rob_pkg::data_t    alu_cdb_value,
    input  logic              alu_cdb_taken,
    input  rob_pkg::data_t    alu_cdb_target,
    input  rob_pkg::rob_tag_t ld_cdb_tag,
    input  rob_pkg::data_t    ld_cdb_value,
    input  rob_pkg::reg_idx_t src1_reg,
    input  rob_pkg::reg_idx_t src2_reg,
    output rob_pkg::rob_tag_t alloc_tag,
    output logic              src1_ready,
    output rob_pkg::data_t    src1_value,
    output rob_pkg::rob_tag_t src1_tag,
    output logic              src2_ready,
    output rob_pkg::data_t    src2_value,
    output rob_pkg::rob_tag_t src2_tag,
    output logic              wb_valid,
    output rob_pkg::reg_idx_t wb_reg,
    output rob_pkg::rob_tag_t wb_tag,
    output rob_pkg::data_t    wb_value,
    output logic              store_commit_valid,
    output rob_pkg::rob_tag_t store_commit_tag,
    output logic              bp_update_valid,
    output rob_pkg::data_t    bp_pc,
    output logic              bp_taken,
    output logic              redirect_valid,
    output rob_pkg::data_t    redirect_pc
);
    import rob_pkg::*;

    logic     alloc_fire;
    logic     flush;
    rob_tag_t query1_tag;
    rob_tag_t query2_tag;
    logic     query1_ready;
    logic     query2_ready;
    data_t    query1_value;
    data_t    query2_value;

    // head entry as seen by the commit logic
    logic     head_ready;
    rob_tag_t head_tag;
    data_t    head_inst;
    reg_idx_t head_dest;
    data_t    head_pc;
    data_t    head_value;
    logic     head_taken;
    data_t    head_target;
    logic     head_pred_taken;

    // register file write at the retiring edge
    logic     reg_we;
    reg_idx_t reg_idx;
    rob_tag_t reg_tag;
    data_t    reg_value;

    rob_buffer buffer0 (.*);

    rob_commit commit0 (.*);

    reg_rename rename0 (
        .wb_we    (reg_we),
        .wb_reg   (reg_idx),
        .wb_tag   (reg_tag),
        .wb_value (reg_value),
        .*
    );

endmodule

//--- tb/rob_tb.sv
`timescale 1ns/1ns
`include "rob_settings.svh"

module rob_tb;
    import rob_pkg::*;

    typedef struct {
        data_t    inst;
        reg_idx_t dest;
        rob_tag_t tag;
        data_t    pc;
        data_t    value;
        logic     pred;
        logic     taken;
        data_t    target;
    } exp_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic alloc_valid, alloc_pred_taken, alu_cdb_taken;
    data_t alloc_inst, alloc_pc, alu_cdb_value, alu_cdb_target, ld_cdb_value;
    reg_idx_t alloc_dest, src1_reg, src2_reg;
    rob_tag_t alu_cdb_tag, ld_cdb_tag;
    rob_tag_t alloc_tag, src1_tag, src2_tag, wb_tag, store_commit_tag;
    logic src1_ready, src2_ready, wb_valid, store_commit_valid;
    logic bp_update_valid, bp_taken, redirect_valid;
    data_t src1_value, src2_value, wb_value, bp_pc, redirect_pc;
    reg_idx_t wb_reg;

    // reference model state
    exp_t     exp_q[$];
    data_t    shadow_reg [0:31];
    rob_tag_t shadow_tag [0:31];
    data_t    comp_value [0:`ROB_SIZE];
    logic     comp_taken [0:`ROB_SIZE];
    data_t    comp_target [0:`ROB_SIZE];
    integer   seed = 7199;
    integer   errors = 0;
    integer   checks = 0;
    integer   cycles = 0;
    integer   test_err;
    data_t    next_pc = 32'h1000;

    rob_core dut0 (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            $display("run stopped: cycle limit of 4000 reached before the tests ended");
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_data(input data_t got, input data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tag(input rob_tag_t got, input rob_tag_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got tag %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input commit_kind_e got, input commit_kind_e exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    // expected kind, redirect and target of a retiring entry
    function automatic commit_kind_e ref_commit(input exp_t e, output logic redir,
                                                output data_t target);
        commit_kind_e k;
        redir  = 1'b0;
        target = e.taken ? e.target : e.pc + 32'd4;
        case (e.inst[6:0])
            7'b0100011: k = CK_STORE;
            7'b1100011: begin
                k     = CK_BRANCH;
                redir = (e.taken != e.pred);
            end
            7'b1100111: begin
                k      = CK_JALR;
                redir  = 1'b1;
                target = e.target;
            end
            default:    k = CK_REG;
        endcase
        return k;
    endfunction

    // compares every commit strobe with the oldest expected entry
    always @(negedge clk) begin
        exp_t e;
        commit_kind_e k;
        commit_kind_e seen;
        logic redir;
        data_t tgt;
        logic want_wb;
        if (!rst && (wb_valid || store_commit_valid || bp_update_valid || redirect_valid)) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected commit strobe at %0t with no instruction pending", $time);
            end else begin
                e = exp_q.pop_front();
                k = ref_commit(e, redir, tgt);
                want_wb = (k == CK_REG || k == CK_JALR) && (e.dest != '0);
                if (store_commit_valid) seen = CK_STORE;
                else if (bp_update_valid && wb_valid) seen = CK_JALR;
                else if (bp_update_valid) seen = CK_BRANCH;
                else seen = CK_REG;
                check_kind(seen, k, "commit kind");
                check_data(data_t'(wb_valid), data_t'(want_wb), "wb_valid");
                if (want_wb) begin
                    check_data(data_t'(wb_reg), data_t'(e.dest), "wb_reg");
                    check_tag(wb_tag, e.tag, "wb_tag");
                    check_data(wb_value, e.value, "wb_value");
                    shadow_reg[e.dest] = e.value;
                    if (shadow_tag[e.dest] == e.tag) shadow_tag[e.dest] = '0;
                end
                if (k == CK_STORE) check_tag(store_commit_tag, e.tag, "store_commit_tag");
                if (k == CK_BRANCH || k == CK_JALR) begin
                    check_data(bp_pc, e.pc, "bp_pc");
                    check_data(data_t'(bp_taken), data_t'(k == CK_JALR || e.taken), "bp_taken");
                end
                check_data(data_t'(redirect_valid), data_t'(redir), "redirect_valid");
                if (redir) begin
                    check_data(redirect_pc, tgt, "redirect_pc");
                    // younger entries are flushed
                    exp_q.delete();
                    for (int i = 0; i < 32; i++) shadow_tag[i] = '0;
                end
            end
        end
    end

    task automatic idle();
        @(posedge clk);
        alloc_valid <= 1'b0;
        alu_cdb_tag <= '0;
        ld_cdb_tag  <= '0;
        @(negedge clk);
    endtask

    task automatic dispatch(input opcode_e op, input reg_idx_t dest, input logic pred,
                            input data_t value, input logic taken, input data_t target,
                            output rob_tag_t tag);
        exp_t e;
        logic redir;
        data_t tgt;
        @(posedge clk);
        alloc_valid      <= 1'b1;
        e.inst            = {25'($random(seed)), op};
        alloc_inst       <= e.inst;
        alloc_dest       <= dest;
        alloc_pc         <= next_pc;
        alloc_pred_taken <= pred;
        alu_cdb_tag      <= '0;
        ld_cdb_tag       <= '0;
        @(negedge clk);
        tag = alloc_tag;
        if (tag != '0) begin
            e.dest = dest;
            e.tag = tag;
            e.pc = next_pc;
            e.value = value;
            e.pred = pred;
            e.taken = taken;
            e.target = target;
            comp_value[tag]  = value;
            comp_taken[tag]  = taken;
            comp_target[tag] = target;
            if (dest != '0) shadow_tag[dest] = tag;
            // a register op to x0 leaves no visible trace
            if (!(ref_commit(e, redir, tgt) == CK_REG && dest == '0)) exp_q.push_back(e);
        end
        next_pc += 32'd4;
    endtask

    task automatic complete(input rob_tag_t alu, input rob_tag_t ld);
        @(posedge clk);
        alloc_valid    <= 1'b0;
        alu_cdb_tag    <= alu;
        alu_cdb_value  <= comp_value[alu];
        alu_cdb_taken  <= comp_taken[alu];
        alu_cdb_target <= comp_target[alu];
        ld_cdb_tag     <= ld;
        ld_cdb_value   <= comp_value[ld];
        @(negedge clk);
    endtask

    task automatic select_src(input reg_idx_t r1, input reg_idx_t r2);
        @(posedge clk);
        alloc_valid <= 1'b0;
        alu_cdb_tag <= '0;
        ld_cdb_tag  <= '0;
        src1_reg    <= r1;
        src2_reg    <= r2;
        @(negedge clk);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) idle();
        repeat (4) idle();
    endtask

    // both sources against the shadow tag table and register file
    task automatic verify_operands(input reg_idx_t r);
        select_src(r, r);
        check_tag(src1_tag, shadow_tag[r], "src1_tag");
        check_tag(src2_tag, shadow_tag[r], "src2_tag");
        if (shadow_tag[r] == '0) begin
            check_data(data_t'(src1_ready), 32'd1, "src1_ready");
            check_data(src1_value, shadow_reg[r], "src1_value");
            check_data(data_t'(src2_ready), 32'd1, "src2_ready");
            check_data(src2_value, shadow_reg[r], "src2_value");
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    task automatic random_batch(input int n);
        rob_tag_t btag [0:15];
        logic     bld [0:15];
        rob_tag_t t;
        logic     tb;
        int       j;
        int       i;
        for (i = 0; i < n; i++) begin
            bld[i] = 1'($random(seed));
            dispatch(bld[i] ? LOAD : OP, reg_idx_t'($random(seed)), 1'b0,
                     $random(seed), 1'b0, '0, btag[i]);
        end
        idle();
        for (i = n - 1; i > 0; i--) begin
            j = {$random(seed)} % (i + 1);
            t = btag[i];
            btag[i] = btag[j];
            btag[j] = t;
            tb = bld[i];
            bld[i] = bld[j];
            bld[j] = tb;
        end
        i = 0;
        while (i < n) begin
            if (i + 1 < n && bld[i] != bld[i + 1]) begin
                complete(bld[i] ? btag[i + 1] : btag[i], bld[i] ? btag[i] : btag[i + 1]);
                i += 2;
            end else begin
                complete(bld[i] ? '0 : btag[i], bld[i] ? btag[i] : '0);
                i += 1;
            end
        end
        idle();
        drain();
    endtask

    task automatic branch_case(input logic pred, input logic taken);
        rob_tag_t b, y1, y2;
        dispatch(BRANCH, '0, pred, '0, taken, 32'h2000 + next_pc, b);
        dispatch(OP, 5'd7, 1'b0, $random(seed), 1'b0, '0, y1);
        dispatch(LOAD, 5'd8, 1'b0, $random(seed), 1'b0, '0, y2);
        complete(y1, y2);
        complete(b, '0);
        idle();
        drain();
        verify_operands(5'd7);
        verify_operands(5'd8);
        check_tag(alloc_tag, rob_tag_t'(1), "alloc_tag after flush");
    endtask

    initial begin
        rob_tag_t tx, ta, tb2, tj, ty;
        rob_tag_t tg [1:15];
        data_t    va;
        alloc_valid = 1'b0;
        alloc_inst = '0;
        alloc_dest = '0;
        alloc_pc = '0;
        alloc_pred_taken = 1'b0;
        alu_cdb_tag = '0;
        alu_cdb_value = '0;
        alu_cdb_taken = 1'b0;
        alu_cdb_target = '0;
        ld_cdb_tag = '0;
        ld_cdb_value = '0;
        src1_reg = '0;
        src2_reg = '0;
        for (int i = 0; i < 32; i++) begin
            shadow_reg[i] = '0;
            shadow_tag[i] = '0;
        end
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_err = 0;
        check_tag(alloc_tag, rob_tag_t'(1), "alloc_tag after reset");

        repeat (3) random_batch(10);
        end_test("1 random alu and load");

        // x6 holds the head so x5 stays in flight
        dispatch(OP, 5'd6, 1'b0, 32'h6666_0001, 1'b0, '0, tx);
        va = $random(seed);
        dispatch(LOAD, 5'd5, 1'b0, va, 1'b0, '0, ta);
        select_src(5'd5, 5'd6);
        check_data(data_t'(src1_ready), 32'd0, "src1_ready pending");
        check_tag(src1_tag, ta, "src1_tag pending");
        check_data(data_t'(src2_ready), 32'd0, "src2_ready pending");
        check_tag(src2_tag, tx, "src2_tag pending");
        complete('0, ta);
        idle();
        check_data(data_t'(src1_ready), 32'd1, "src1_ready completed");
        check_data(src1_value, va, "src1_value completed");
        dispatch(OP, 5'd5, 1'b0, $random(seed), 1'b0, '0, tb2);
        idle();
        check_tag(src1_tag, tb2, "src1_tag newer dispatch");
        complete(tx, '0);
        while (exp_q.size() > 1) idle();
        check_tag(src1_tag, tb2, "src1_tag after older commit");
        check_data(data_t'(src1_ready), 32'd0, "src1_ready newer pending");
        complete(tb2, '0);
        idle();
        drain();
        verify_operands(5'd5);
        verify_operands(5'd6);
        end_test("2 operand resolution");

        dispatch(STORE, '0, 1'b0, $random(seed), 1'b0, '0, tx);
        complete(tx, '0);
        idle();
        drain();
        end_test("4 store commit");

        dispatch(BRANCH, '0, 1'b1, '0, 1'b1, 32'h0000_4000, tx);
        complete(tx, '0);
        idle();
        drain();
        branch_case(1'b0, 1'b1);
        branch_case(1'b1, 1'b0);
        end_test("5 branches");

        dispatch(JALR, 5'd9, 1'b0, next_pc + 32'd4, 1'b0, 32'h0000_8800, tj);
        dispatch(OP, 5'd10, 1'b0, $random(seed), 1'b0, '0, ty);
        complete(ty, '0);
        complete(tj, '0);
        idle();
        drain();
        verify_operands(5'd9);
        verify_operands(5'd10);
        check_tag(alloc_tag, rob_tag_t'(1), "alloc_tag after jalr");
        end_test("6 jalr");

        for (int i = 1; i <= 15; i++) begin
            dispatch(OP, reg_idx_t'(i + 10), 1'b0, $random(seed), 1'b0, '0, tg[i]);
            check_tag(tg[i], rob_tag_t'(i), "allocated tag");
        end
        dispatch(OP, 5'd3, 1'b0, 32'hdead_beef, 1'b0, '0, tx);
        check_tag(tx, '0, "alloc_tag when full");
        for (int i = 15; i >= 1; i--) complete(tg[i], '0);
        idle();
        drain();
        end_test("3 full buffer");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+rtl
rtl/rob_pkg.sv
rtl/rob_buffer.sv
rtl/rob_commit.sv
rtl/reg_rename.sv
rtl/rob_core.sv
tb/rob_tb.sv

//--- Makefile
# Verilator build and run for the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= rob_tb
FILELIST  ?= src.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "PASS: all tests" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
